// File: Bender.yml
package:
  name: frontend_top

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/fe_types_pkg.sv
      - hw/fe_csr_pkg.sv
      - hw/trap_csr.sv
      - hw/fetch.sv
      - hw/instr_mem.sv
      - hw/frontend_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - tb/frontend_properties.sv
      - tb/frontend_checker.sv
      - tb/tb_frontend_top.sv

// File: frontend_top.f
+incdir+include
hw/fe_types_pkg.sv
hw/fe_csr_pkg.sv
hw/trap_csr.sv
hw/fetch.sv
hw/instr_mem.sv
hw/frontend_top.sv
tb/frontend_properties.sv
tb/frontend_checker.sv
tb/tb_frontend_top.sv

// File: hw/fe_csr_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~
// trap register package
// selector for the mtvec / mepc configuration port
// ~~~~~~~~~~~~~~~~~~~~

package fe_csr_pkg;

    // which trap register a config write targets
    //   CSR_MTVEC : trap entry vector
    //   CSR_MEPC  : return address used by mret
    typedef enum logic {
        CSR_MTVEC = 1'b0, // trap vector
        CSR_MEPC  = 1'b1  // exception pc
    } csr_sel_t;

endpackage

// File: hw/fe_types_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~
// front end types
// vector typedefs shared by fetch, imem and the trap registers
// ~~~~~~~~~~~~~~~~~~~~

package fe_types_pkg;

    // byte address, pc and redirect targets
    typedef logic [31:0] addr_t;

    // raw instruction word as read from imem
    typedef logic [31:0] instr_t;

    // flow tag, bumped on every redirect
    typedef logic [2:0] tag_t;

    // word index into imem, covers 256 words
    typedef logic [7:0] imem_index_t;

endpackage

// File: hw/fetch.sv
// ~~~~~~~~~~~~~~~~~~~~
// fetch stage
// pc register with redirect priority, flow tag calculator
// and the issued pc that leaves with the instruction
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "frontend_config.svh"

module fetch (
    input  logic                 clk,
    input  logic                 reset,

    // pipeline hold levels
    input  logic                 stall_i,
    input  logic                 hazard_i,

    // jump redirect from execute
    input  logic                 jump_i,
    input  fe_types_pkg::addr_t  jump_target_i,

    // trap redirect sources
    input  fe_types_pkg::addr_t  mtvec_i,
    input  fe_types_pkg::addr_t  mepc_i,
    input  logic                 exception_raised_i,
    input  logic                 machine_return_i,
    input  logic                 interrupt_ack_i,

    // to instruction memory
    output fe_types_pkg::addr_t  fetch_addr_o,
    output logic                 fetch_advance_o,

    // issued instruction info
    output fe_types_pkg::addr_t  pc_o,
    output fe_types_pkg::tag_t   tag_o
);

    import fe_types_pkg::*;

    addr_t pc;            // current fetch address
    addr_t pc_plus4;      // sequential successor
    addr_t pc_next;       // value loaded on the next edge
    addr_t pc_issued;     // pc travelling with instr
    tag_t  next_tag;      // tag for the flow after a redirect
    tag_t  current_tag;   // tag of the flow being issued
    logic  advance;       // pipeline accepts this cycle
    logic  trap_redirect; // exception or irq ack
    logic  redirect;      // any pc redirect

    // the one place the accept condition is formed
    // held low during reset so no garbage is issued
    assign advance       = !stall_i && !hazard_i && !reset;
    assign trap_redirect = exception_raised_i || interrupt_ack_i;
    assign redirect      = machine_return_i || trap_redirect || jump_i;
    assign pc_plus4      = pc + 32'd4;

    // redirect priority, mret highest
    // redirects apply even while the pipe is held
    always_comb begin
        if (machine_return_i) begin
            pc_next = mepc_i;          // resume after trap
        end else if (trap_redirect) begin
            pc_next = mtvec_i;         // trap entry
        end else if (jump_i) begin
            pc_next = jump_target_i;
        end else if (advance) begin
            pc_next = pc_plus4;        // sequential flow
        end else begin
            pc_next = pc;              // hold
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `FE_START_ADDRESS;
        end else begin
            pc <= pc_next;
        end
    end

    // issued pc, captured on the same edge imem registers its word
    always_ff @(posedge clk) begin
        if (advance) begin
            pc_issued <= pc;
        end
    end

    // tag calculator
    // a redirect opens a new flow, the issued tag follows on the next advance
    always_ff @(posedge clk) begin
        if (reset) begin
            next_tag    <= '0;
            current_tag <= '0;
        end else if (redirect) begin
            next_tag <= next_tag + 3'd1;   // wraps at eight
        end else if (advance) begin
            current_tag <= next_tag;
        end
    end

    assign fetch_addr_o    = pc;         // combinational fetch address
    assign fetch_advance_o = advance;
    assign pc_o            = pc_issued;
    assign tag_o           = current_tag;

endmodule

// File: hw/frontend_top.sv
// ~~~~~~~~~~~~~~~~~~~~
// instruction front end
// fetch stage, trap registers and instruction memory
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module frontend_top (
    input  logic                       clk,
    input  logic                       reset,

    // hold levels from later stages
    input  logic                       stall_i,
    input  logic                       hazard_i,

    // redirects and trap events
    input  logic                       jump_i,
    input  fe_types_pkg::addr_t        jump_target_i,
    input  logic                       exception_raised_i,
    input  fe_types_pkg::addr_t        exception_pc_i,
    input  logic                       interrupt_ack_i,
    input  logic                       machine_return_i,

    // trap register config port
    input  logic                       csr_we_i,
    input  fe_csr_pkg::csr_sel_t       csr_sel_i,
    input  fe_types_pkg::addr_t        csr_wdata_i,

    // imem load port
    input  logic                       imem_we_i,
    input  fe_types_pkg::imem_index_t  imem_waddr_i,
    input  fe_types_pkg::instr_t       imem_wdata_i,

    // issued instruction
    output fe_types_pkg::instr_t       instr_o,
    output fe_types_pkg::addr_t        pc_o,
    output fe_types_pkg::tag_t         tag_o
);

    import fe_types_pkg::*;

    addr_t mtvec;          // trap vector to fetch
    addr_t mepc;           // return address to fetch
    addr_t fetch_addr;     // pc presented to imem
    logic  fetch_advance;  // imem read enable

    trap_csr u_trap_csr (
        .clk                (clk),
        .reset              (reset),
        .csr_we_i           (csr_we_i),
        .csr_sel_i          (csr_sel_i),
        .csr_wdata_i        (csr_wdata_i),
        .exception_raised_i (exception_raised_i),
        .interrupt_ack_i    (interrupt_ack_i),
        .exception_pc_i     (exception_pc_i),
        .mtvec_o            (mtvec),
        .mepc_o             (mepc)
    );

    fetch u_fetch (
        .clk                (clk),
        .reset              (reset),
        .stall_i            (stall_i),
        .hazard_i           (hazard_i),
        .jump_i             (jump_i),
        .jump_target_i      (jump_target_i),
        .mtvec_i            (mtvec),
        .mepc_i             (mepc),
        .exception_raised_i (exception_raised_i),
        .machine_return_i   (machine_return_i),
        .interrupt_ack_i    (interrupt_ack_i),
        .fetch_addr_o       (fetch_addr),
        .fetch_advance_o    (fetch_advance),
        .pc_o               (pc_o),
        .tag_o              (tag_o)
    );

    instr_mem u_instr_mem (
        .clk                (clk),
        .imem_we_i          (imem_we_i),
        .imem_waddr_i       (imem_waddr_i),
        .imem_wdata_i       (imem_wdata_i),
        .read_addr_i        (fetch_addr),
        .read_en_i          (fetch_advance),
        .instr_o            (instr_o)
    );

endmodule

// File: hw/instr_mem.sv
// ~~~~~~~~~~~~~~~~~~~~
// instruction memory
// word array with a load port and an enabled registered read
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "frontend_config.svh"

module instr_mem (
    input  logic                       clk,

    // load port, used to preload the program
    input  logic                       imem_we_i,
    input  fe_types_pkg::imem_index_t  imem_waddr_i,
    input  fe_types_pkg::instr_t       imem_wdata_i,

    // fetch side
    input  fe_types_pkg::addr_t        read_addr_i,
    input  logic                       read_en_i,
    output fe_types_pkg::instr_t       instr_o
);

    import fe_types_pkg::*;

    instr_t      mem [`FE_IMEM_WORDS];  // program storage
    instr_t      rdata_q;               // read register
    imem_index_t read_index;            // word index of the fetch address

    // byte address to word index, bits 9..2
    // upper bits ignored, the memory aliases over the address space
    assign read_index = read_addr_i[9:2];

    // load port write
    always_ff @(posedge clk) begin
        if (imem_we_i) begin
            mem[imem_waddr_i] <= imem_wdata_i;
        end
    end

    // registered read, holds while the pipe is held
    always_ff @(posedge clk) begin
        if (read_en_i) begin
            rdata_q <= mem[read_index];
        end
    end

    assign instr_o = rdata_q;   // leaves together with pc_o

endmodule

// File: hw/trap_csr.sv
// ~~~~~~~~~~~~~~~~~~~~
// trap register block
// holds mtvec and mepc, config write port, mepc capture on trap
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "frontend_config.svh"

module trap_csr (
    input  logic                  clk,
    input  logic                  reset,

    // configuration write port
    input  logic                  csr_we_i,
    input  fe_csr_pkg::csr_sel_t  csr_sel_i,
    input  fe_types_pkg::addr_t   csr_wdata_i,

    // trap events from the back end
    input  logic                  exception_raised_i,
    input  logic                  interrupt_ack_i,
    input  fe_types_pkg::addr_t   exception_pc_i,

    // continuous view for fetch
    output fe_types_pkg::addr_t   mtvec_o,
    output fe_types_pkg::addr_t   mepc_o
);

    import fe_types_pkg::*;
    import fe_csr_pkg::*;

    addr_t mtvec_q;      // trap entry vector
    addr_t mepc_q;       // return address
    logic  trap_taken;   // exception or interrupt this cycle
    logic  wr_mtvec;     // sw write to mtvec
    logic  wr_mepc;      // sw write to mepc

    assign trap_taken = exception_raised_i || interrupt_ack_i;
    assign wr_mtvec   = csr_we_i && (csr_sel_i == CSR_MTVEC);
    assign wr_mepc    = csr_we_i && (csr_sel_i == CSR_MEPC);

    // mtvec only changes through the config port
    always_ff @(posedge clk) begin
        if (reset) begin
            mtvec_q <= `FE_MTVEC_RESET;
        end else if (wr_mtvec) begin
            mtvec_q <= csr_wdata_i;
        end
    end

    // mepc, trap capture beats a sw write in the same cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            mepc_q <= '0;
        end else if (trap_taken) begin
            mepc_q <= exception_pc_i;    // faulting pc
        end else if (wr_mepc) begin
            mepc_q <= csr_wdata_i;
        end
    end

    // fetch samples the old mtvec on the trap edge
    assign mtvec_o = mtvec_q;
    assign mepc_o  = mepc_q;

endmodule

// File: include/frontend_config.svh
// ~~~~~~~~~~~~~~~~~~~~
// frontend configuration
// reset values and memory sizing for the instruction front end
// ~~~~~~~~~~~~~~~~~~~~

`ifndef FRONTEND_CONFIG_SVH
`define FRONTEND_CONFIG_SVH

// pc loaded on reset, first fetched word
`define FE_START_ADDRESS 32'h0000_0000

// instruction memory depth in 32-bit words
`define FE_IMEM_WORDS 256

// trap vector after reset, inside the imem window
`define FE_MTVEC_RESET 32'h0000_0200

`endif

// File: tb/frontend_checker.sv
// ~~~~~~~~~~~~~~~~~~~~
// front end checker
// reference model of pc, tags, trap registers and imem contents,
// compares the issued pc, instr and tag on every cycle
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "frontend_config.svh"

module frontend_checker (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  stall_i,
    input  logic                  hazard_i,
    input  logic                  jump_i,
    input  fe_types_pkg::addr_t   jump_target_i,
    input  logic                  exception_raised_i,
    input  fe_types_pkg::addr_t   exception_pc_i,
    input  logic                  interrupt_ack_i,
    input  logic                  machine_return_i,
    input  logic                  csr_we_i,
    input  fe_csr_pkg::csr_sel_t  csr_sel_i,
    input  fe_types_pkg::addr_t   csr_wdata_i,
    input  fe_types_pkg::instr_t  instr_i,
    input  fe_types_pkg::addr_t   pc_i,
    input  fe_types_pkg::tag_t    tag_i,
    output int                    pc_errors_o,
    output int                    instr_errors_o,
    output int                    tag_errors_o,
    output int                    checks_o
);

    import fe_types_pkg::*;
    import fe_csr_pkg::*;

    instr_t     ref_mem [`FE_IMEM_WORDS];  // filled by the tb during preload
    addr_t      m_pc;                      // model fetch address
    addr_t      m_issued_pc;               // expected pc_o
    instr_t     m_exp_instr;               // expected instr_o
    tag_t       m_next_tag;
    tag_t       m_cur_tag;                 // expected tag_o
    addr_t      m_mtvec;
    addr_t      m_mepc;
    logic       check_due;                 // an instruction has been issued
    logic       adv;
    logic       trap;
    logic       redirect;
    logic [5:0] tags_next;                 // {next, current}
    int         pc_errors = 0;
    int         instr_errors = 0;
    int         tag_errors = 0;
    int         checks = 0;

    // priority: mret, trap, jump, advance, hold
    function automatic addr_t next_pc_ref(input logic mret, input logic trp, input logic jmp,
                                          input logic advance, input addr_t cur_pc,
                                          input addr_t jtgt, input addr_t vec, input addr_t epc);
        if (mret)
            return epc;
        else if (trp)
            return vec;
        else if (jmp)
            return jtgt;
        else if (advance)
            return cur_pc + 32'd4;
        return cur_pc;
    endfunction

    // redirect bumps next tag, advance hands it to the current tag
    function automatic logic [5:0] next_tags_ref(input logic redir, input logic advance,
                                                 input tag_t nxt, input tag_t cur);
        if (redir)
            return {tag_t'(nxt + 3'd1), cur};   // wraps at eight
        else if (advance)
            return {nxt, nxt};
        return {nxt, cur};
    endfunction

    assign adv       = !stall_i && !hazard_i;
    assign trap      = exception_raised_i || interrupt_ack_i;
    assign redirect  = machine_return_i || trap || jump_i;
    assign tags_next = next_tags_ref(redirect, adv, m_next_tag, m_cur_tag);

    always @(posedge clk) begin
        if (reset) begin
            m_pc       <= `FE_START_ADDRESS;
            m_next_tag <= '0;
            m_cur_tag  <= '0;
            m_mtvec    <= `FE_MTVEC_RESET;
            m_mepc     <= '0;
            check_due  <= 1'b0;
        end else begin
            m_pc <= next_pc_ref(machine_return_i, trap, jump_i, adv, m_pc,
                                jump_target_i, m_mtvec, m_mepc);
            {m_next_tag, m_cur_tag} <= tags_next;
            if (adv) begin
                m_issued_pc <= m_pc;
                m_exp_instr <= ref_mem[m_pc[9:2]];   // word index, imem aliases
                check_due   <= 1'b1;                 // outputs defined from here on
            end
            if (csr_we_i && csr_sel_i == CSR_MTVEC)
                m_mtvec <= csr_wdata_i;
            if (trap)
                m_mepc <= exception_pc_i;            // capture beats sw write
            else if (csr_we_i && csr_sel_i == CSR_MEPC)
                m_mepc <= csr_wdata_i;
        end
    end

    // outputs settled by the falling edge, held values compared too
    always @(negedge clk) begin
        if (check_due && !reset) begin
            checks++;
            if (pc_i !== m_issued_pc) begin
                $display("FAIL pc_o at %0t: got 0x%08h expected 0x%08h", $time, pc_i, m_issued_pc);
                pc_errors++;
            end
            if (instr_i !== m_exp_instr) begin
                $display("FAIL instr_o at %0t: got 0x%08h expected 0x%08h",
                         $time, instr_i, m_exp_instr);
                instr_errors++;
            end
            if (tag_i !== m_cur_tag) begin
                $display("FAIL tag_o at %0t: got 0x%h expected 0x%h", $time, tag_i, m_cur_tag);
                tag_errors++;
            end
        end
    end

    assign pc_errors_o    = pc_errors;
    assign instr_errors_o = instr_errors;
    assign tag_errors_o   = tag_errors;
    assign checks_o       = checks;

endmodule

// File: tb/frontend_properties.sv
// ~~~~~~~~~~~~~~~~~~~~
// front end assertions
// bound into frontend_top, watch issued pc, tag and fetch address
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module frontend_properties (
    input logic                 clk,
    input logic                 reset,
    input logic                 stall_i,
    input logic                 jump_i,
    input fe_types_pkg::addr_t  jump_target_i,
    input logic                 exception_raised_i,
    input logic                 interrupt_ack_i,
    input logic                 machine_return_i,
    input fe_types_pkg::addr_t  fetch_addr_i,
    input fe_types_pkg::addr_t  pc_i,
    input fe_types_pkg::tag_t   tag_i
);

    logic trap;                  // exception or irq ack
    logic redirect;              // any pc redirect
    int   assert_failures = 0;   // summed into the final report

    assign trap     = exception_raised_i || interrupt_ack_i;
    assign redirect = machine_return_i || trap || jump_i;

    // issued pc and tag frozen while stalled
    hold_under_stall: assert property (
        @(posedge clk) disable iff (reset)
        (stall_i && !redirect && !$isunknown(pc_i)) |=> ($stable(pc_i) && $stable(tag_i))
    ) else begin
        $error("issued pc or tag changed under stall");
        assert_failures++;
    end

    fetch_aligned: assert property (
        @(posedge clk) disable iff (reset)
        (fetch_addr_i[1:0] == 2'b00)
    ) else begin
        $error("fetch address not word aligned");
        assert_failures++;
    end

    // plain jump, no trap or mret competing
    jump_lands: assert property (
        @(posedge clk) disable iff (reset)
        (jump_i && !machine_return_i && !trap) |=> (fetch_addr_i == $past(jump_target_i))
    ) else begin
        $error("fetch address does not match jump target");
        assert_failures++;
    end

endmodule

// File: tb/tb_frontend_top.sv
// ~~~~~~~~~~~~~~~~~~~~
// front end testbench
// clock, reset, imem preload, directed redirects and random holds
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "frontend_config.svh"

module tb_frontend_top;

    import fe_types_pkg::*;
    import fe_csr_pkg::*;

    logic        clk;
    logic        reset;
    logic        stall;
    logic        hazard;
    logic        jump;
    addr_t       jump_target;
    logic        exception_raised;
    addr_t       exception_pc;
    logic        interrupt_ack;
    logic        machine_return;
    logic        csr_we;
    csr_sel_t    csr_sel;
    addr_t       csr_wdata;
    logic        imem_we;
    imem_index_t imem_waddr;
    instr_t      imem_wdata;
    instr_t      instr;
    addr_t       pc;
    tag_t        tag;

    int          pc_errors;
    int          instr_errors;
    int          tag_errors;
    int          checks;
    int          timeout_errors = 0;
    int          directed_errors = 0;
    int          total;
    integer      seed;
    logic [31:0] rnd;
    addr_t       target;
    tag_t        first_tag;

    frontend_top DUT (
        .clk                (clk),
        .reset              (reset),
        .stall_i            (stall),
        .hazard_i           (hazard),
        .jump_i             (jump),
        .jump_target_i      (jump_target),
        .exception_raised_i (exception_raised),
        .exception_pc_i     (exception_pc),
        .interrupt_ack_i    (interrupt_ack),
        .machine_return_i   (machine_return),
        .csr_we_i           (csr_we),
        .csr_sel_i          (csr_sel),
        .csr_wdata_i        (csr_wdata),
        .imem_we_i          (imem_we),
        .imem_waddr_i       (imem_waddr),
        .imem_wdata_i       (imem_wdata),
        .instr_o            (instr),
        .pc_o               (pc),
        .tag_o              (tag)
    );

    frontend_checker u_checker (
        .clk                (clk),
        .reset              (reset),
        .stall_i            (stall),
        .hazard_i           (hazard),
        .jump_i             (jump),
        .jump_target_i      (jump_target),
        .exception_raised_i (exception_raised),
        .exception_pc_i     (exception_pc),
        .interrupt_ack_i    (interrupt_ack),
        .machine_return_i   (machine_return),
        .csr_we_i           (csr_we),
        .csr_sel_i          (csr_sel),
        .csr_wdata_i        (csr_wdata),
        .instr_i            (instr),
        .pc_i               (pc),
        .tag_i              (tag),
        .pc_errors_o        (pc_errors),
        .instr_errors_o     (instr_errors),
        .tag_errors_o       (tag_errors),
        .checks_o           (checks)
    );

    bind frontend_top frontend_properties u_properties (
        .clk                (clk),
        .reset              (reset),
        .stall_i            (stall_i),
        .jump_i             (jump_i),
        .jump_target_i      (jump_target_i),
        .exception_raised_i (exception_raised_i),
        .interrupt_ack_i    (interrupt_ack_i),
        .machine_return_i   (machine_return_i),
        .fetch_addr_i       (fetch_addr),
        .pc_i               (pc_o),
        .tag_i              (tag_o)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;   // 20 ns period
    end

    // preload every word, the checker gets the same copy
    task automatic load_memory;
        instr_t word;
        for (int i = 0; i < `FE_IMEM_WORDS; i++) begin
            word = $random(seed);
            @(posedge clk);
            imem_we    <= 1'b1;
            imem_waddr <= imem_index_t'(i);
            imem_wdata <= word;
            u_checker.ref_mem[i] = word;
        end
        @(posedge clk);
        imem_we <= 1'b0;
    endtask

    task automatic run_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    task automatic random_holds(input int stretches);
        logic [31:0] r;
        for (int s = 0; s < stretches; s++) begin
            r = $random(seed);
            @(posedge clk);
            stall  <= r[0];
            hazard <= r[1];
            repeat (r[4:2]) @(posedge clk);   // stretch length
        end
        @(posedge clk);
        stall  <= 1'b0;
        hazard <= 1'b0;
    endtask

    task automatic pulse_jump(input addr_t tgt, input logic hold);
        @(posedge clk);
        stall       <= hold;   // redirect must land even when held
        jump        <= 1'b1;
        jump_target <= tgt;
        @(posedge clk);
        jump  <= 1'b0;
        stall <= 1'b0;
    endtask

    task automatic pulse_trap(input logic is_irq, input addr_t epc);
        @(posedge clk);
        exception_raised <= !is_irq;
        interrupt_ack    <= is_irq;
        exception_pc     <= epc;
        @(posedge clk);
        exception_raised <= 1'b0;
        interrupt_ack    <= 1'b0;
    endtask

    // optional jump in the same cycle, mret must win
    task automatic pulse_mret(input logic with_jump, input addr_t tgt);
        @(posedge clk);
        machine_return <= 1'b1;
        jump           <= with_jump;
        jump_target    <= tgt;
        @(posedge clk);
        machine_return <= 1'b0;
        jump           <= 1'b0;
    endtask

    task automatic csr_write(input csr_sel_t sel, input addr_t data);
        @(posedge clk);
        csr_we    <= 1'b1;
        csr_sel   <= sel;
        csr_wdata <= data;
        @(posedge clk);
        csr_we <= 1'b0;
    endtask

    task automatic wait_for_issue(input addr_t target_pc, input int limit);
        int waited;
        waited = 0;
        @(negedge clk);
        while (pc !== target_pc && waited < limit) begin
            @(negedge clk);
            waited++;
        end
        if (pc !== target_pc) begin
            $display("timeout: pc 0x%08h was not issued within %0d cycles", target_pc, limit);
            timeout_errors++;
        end
    endtask

    initial begin
        seed             = 32'h4534;
        reset            = 1'b1;
        stall            = 1'b1;   // held through the preload
        hazard           = 1'b0;
        jump             = 1'b0;
        jump_target      = '0;
        exception_raised = 1'b0;
        exception_pc     = '0;
        interrupt_ack    = 1'b0;
        machine_return   = 1'b0;
        csr_we           = 1'b0;
        csr_sel          = CSR_MTVEC;
        csr_wdata        = '0;
        imem_we          = 1'b0;
        imem_waddr       = '0;
        imem_wdata       = '0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        load_memory();

        // sequential flow from the start address
        @(posedge clk);
        stall <= 1'b0;
        wait_for_issue(`FE_START_ADDRESS + 32'd40, 50);

        random_holds(15);
        run_cycles(5);

        // nine jumps, tag must come back around after eight
        target = '0;
        for (int j = 0; j < 9; j++) begin
            rnd    = $random(seed);
            target = target + 32'h100 + {rnd[5:0], 2'b00};   // far from the last flow
            pulse_jump(target, rnd[8]);
            wait_for_issue(target, 20);
            if (j == 0) begin
                first_tag = tag;
            end else if (tag !== tag_t'(first_tag + j)) begin
                $display("FAIL tag_o after jump %0d: got 0x%h expected 0x%h",
                         j, tag, tag_t'(first_tag + j));
                directed_errors++;
            end
            run_cycles(2);
        end

        // exception then mret, irq ack then mret
        pulse_trap(1'b0, 32'h0000_0120);
        wait_for_issue(`FE_MTVEC_RESET, 20);
        run_cycles(4);
        pulse_mret(1'b0, '0);
        wait_for_issue(32'h0000_0120, 20);
        run_cycles(3);
        pulse_trap(1'b1, 32'h0000_00a0);
        wait_for_issue(`FE_MTVEC_RESET, 20);
        run_cycles(3);
        pulse_mret(1'b0, '0);
        wait_for_issue(32'h0000_00a0, 20);

        // moved trap vector, then mret racing a jump
        csr_write(CSR_MTVEC, 32'h0000_0300);
        run_cycles(2);
        pulse_trap(1'b0, 32'h0000_0044);
        wait_for_issue(32'h0000_0300, 20);
        run_cycles(3);
        pulse_mret(1'b1, 32'h0000_0080);
        wait_for_issue(32'h0000_0044, 20);

        // sw write of mepc, then a trap that overrides a same cycle write
        csr_write(CSR_MEPC, 32'h0000_0010);
        pulse_mret(1'b0, '0);
        wait_for_issue(32'h0000_0010, 20);
        @(posedge clk);
        exception_raised <= 1'b1;
        exception_pc     <= 32'h0000_0068;
        csr_we           <= 1'b1;
        csr_sel          <= CSR_MEPC;
        csr_wdata        <= 32'h0000_00f0;
        @(posedge clk);
        exception_raised <= 1'b0;
        csr_we           <= 1'b0;
        wait_for_issue(32'h0000_0300, 20);
        pulse_mret(1'b0, '0);
        wait_for_issue(32'h0000_0068, 20);

        random_holds(10);
        run_cycles(4);
        @(negedge clk);

        if (checks == 0) begin
            $display("no issued instruction was compared");
            directed_errors++;
        end
        total = pc_errors + instr_errors + tag_errors + timeout_errors + directed_errors
              + DUT.u_properties.assert_failures;
        $display("errors: pc %0d instr %0d tag %0d timeout %0d directed %0d assert %0d (%0d checks)",
                 pc_errors, instr_errors, tag_errors, timeout_errors, directed_errors,
                 DUT.u_properties.assert_failures, checks);
        if (total == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule
